// File: rtl/alu_adder.sv
/*
 * Lane-wise adder of the SIMD ALU: wrapping add and subtract, saturating
 * add and subtract, and averaging add with the configured rounding mode.
 * Each element is extended by two guard bits so sum and overflow are exact.
 */

`timescale 1ns/1ns

module alu_adder (
  input  simd_alu_pkg::alu_req_t    req_i,
  input  simd_alu_pkg::alu_cfg_t    cfg_i,
  output simd_alu_pkg::elen_t       add_res_o,
  output simd_alu_pkg::lane_flags_t sat_lanes_o
);

  import simd_alu_pkg::*;

  logic  is_signed;
  elen_t mask;
  ext_t  umax;
  ext_t  smax;
  ext_t  ea;
  ext_t  eb;
  ext_t  full;
  elen_t val;
  logic  sat;
  logic  rnd;

  assign is_signed = req_i.op inside {VSADD, VSSUB, VAADD};
  assign mask      = ew_mask(cfg_i.vew);
  assign umax      = {2'b00, mask};
  assign smax      = {2'b00, mask >> 1};

  always_comb begin
    add_res_o   = '0;
    sat_lanes_o = '0;
    ea          = '0;
    eb          = '0;
    full        = '0;
    val         = '0;
    sat         = 1'b0;
    rnd         = 1'b0;
    for (int unsigned e = 0; e < NumLanes8; e++) begin
      if (e < ew_count(cfg_i.vew)) begin
        ea = elem_ext(req_i.opa, cfg_i.vew, e, is_signed);
        eb = elem_ext(req_i.opb, cfg_i.vew, e, is_signed);

        unique case (req_i.op)
          VSUB, VSSUBU, VSSUB: full = eb - ea;
          VRSUB:               full = ea - eb;
          default:             full = ea + eb;
        endcase

        // Rounding increment from the two lowest bits of the exact sum
        unique case (cfg_i.vxrm)
          RNU:     rnd = full[0];
          RNE:     rnd = full[0] & full[1];
          RDN:     rnd = 1'b0;
          ROD:     rnd = full[0] & ~full[1];
          default: rnd = 1'b0;
        endcase

        sat = 1'b0;
        val = full[ElenBits-1:0];
        unique case (req_i.op)
          VSADDU: begin
            if (full > umax) begin
              sat = 1'b1;
              val = '1;
            end
          end
          VSSUBU: begin
            // Negative difference means a borrow
            if (full[ExtBits-1]) begin
              sat = 1'b1;
              val = '0;
            end
          end
          VSADD, VSSUB: begin
            if ($signed(full) > $signed(smax)) begin
              sat = 1'b1;
              val = smax[ElenBits-1:0];
            end else if ($signed(full) < $signed(~smax)) begin
              sat = 1'b1;
              val = ~smax[ElenBits-1:0];
            end
          end
          VAADDU, VAADD: begin
            val = elen_t'(($signed(full) >>> 1) + $signed({1'b0, rnd}));
          end
          default: ;
        endcase

        add_res_o = elem_put(add_res_o, cfg_i.vew, e, val);
        sat_lanes_o[e << cfg_i.vew] = sat;
      end
    end
  end

endmodule

// File: rtl/alu_compare.sv
/*
 * Per-element magnitude and equality compare at the configured width.
 * Flags land on the lowest byte lane of each element, other lanes stay 0.
 * Feeds min/max selection and the compare ops in writeback.
 */

`timescale 1ns/1ns

module alu_compare (
  input  simd_alu_pkg::alu_req_t    req_i,
  input  simd_alu_pkg::alu_cfg_t    cfg_i,
  output simd_alu_pkg::lane_flags_t less_o,
  output simd_alu_pkg::lane_flags_t equal_o
);

  import simd_alu_pkg::*;

  logic is_signed;
  ext_t ea;
  ext_t eb;

  assign is_signed = req_i.op inside {VMIN, VMAX, VMSLT, VMSLE, VMSGT};

  always_comb begin
    less_o  = '0;
    equal_o = '0;
    ea      = '0;
    eb      = '0;
    for (int unsigned e = 0; e < NumLanes8; e++) begin
      if (e < ew_count(cfg_i.vew)) begin
        ea = elem_ext(req_i.opa, cfg_i.vew, e, is_signed);
        eb = elem_ext(req_i.opb, cfg_i.vew, e, is_signed);
        // b < a, signed compare also covers zero-extended unsigned values
        less_o[e << cfg_i.vew]  = $signed(eb) < $signed(ea);
        equal_o[e << cfg_i.vew] = (ea == eb);
      end
    end
  end

endmodule

// File: rtl/alu_csr.sv
/*
 * Configuration and status block of the SIMD ALU.
 * Holds element width and rounding mode from the config strobe, and the
 * sticky saturation flag raised by writeback and cleared by any config write.
 */

`timescale 1ns/1ns

module alu_csr (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  cfg_we_i,
  input  simd_alu_pkg::alu_cfg_t cfg_i,
  input  logic                  sat_set_i,
  output simd_alu_pkg::alu_cfg_t cfg_o,
  output logic                  vxsat_o
);

  import simd_alu_pkg::*;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cfg_o.vew  <= EW8;
      cfg_o.vxrm <= RNU;
    end else if (cfg_we_i) begin
      cfg_o <= cfg_i;
    end
  end

  // Set has priority over the clear from a config write
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      vxsat_o <= 1'b0;
    end else if (sat_set_i) begin
      vxsat_o <= 1'b1;
    end else if (cfg_we_i) begin
      vxsat_o <= 1'b0;
    end
  end

endmodule

// File: rtl/alu_shifter.sv
/*
 * Lane-wise shifter of the SIMD ALU.
 * Operand b is shifted by the low log2(width) bits of the matching
 * element of operand a, left, right logical or right arithmetic.
 */

`timescale 1ns/1ns

module alu_shifter (
  input  simd_alu_pkg::alu_req_t req_i,
  input  simd_alu_pkg::alu_cfg_t cfg_i,
  output simd_alu_pkg::elen_t    shift_res_o
);

  import simd_alu_pkg::*;

  ext_t       ea;
  ext_t       eb;
  logic [5:0] shamt;
  elen_t      val;

  always_comb begin
    shift_res_o = '0;
    ea          = '0;
    eb          = '0;
    shamt       = '0;
    val         = '0;
    for (int unsigned e = 0; e < NumLanes8; e++) begin
      if (e < ew_count(cfg_i.vew)) begin
        ea    = elem_ext(req_i.opa, cfg_i.vew, e, 1'b0);
        // Sign extension only for arithmetic shifts
        eb    = elem_ext(req_i.opb, cfg_i.vew, e, req_i.op == VSRA);
        shamt = ea[5:0] & 6'(ew_bits(cfg_i.vew) - 1);
        unique case (req_i.op)
          VSLL:    val = elen_t'(eb << shamt);
          VSRL:    val = elen_t'(eb >> shamt);
          VSRA:    val = elen_t'($signed(eb) >>> shamt);
          default: val = '0;
        endcase
        shift_res_o = elem_put(shift_res_o, cfg_i.vew, e, val);
      end
    end
  end

endmodule

// File: rtl/alu_writeback.sv
/*
 * Result selection and output register of the SIMD ALU.
 * Logic ops are computed here, min/max and compares are built from the
 * lane flags, and the chosen word is registered with valid.
 */

`timescale 1ns/1ns

module alu_writeback (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      valid_i,
  input  simd_alu_pkg::alu_req_t    req_i,
  input  simd_alu_pkg::alu_cfg_t    cfg_i,
  input  simd_alu_pkg::lane_flags_t less_i,
  input  simd_alu_pkg::lane_flags_t equal_i,
  input  simd_alu_pkg::elen_t       add_res_i,
  input  simd_alu_pkg::lane_flags_t sat_lanes_i,
  input  simd_alu_pkg::elen_t       shift_res_i,
  output simd_alu_pkg::elen_t       result_o,
  output logic                      valid_o,
  output logic                      sat_set_o
);

  import simd_alu_pkg::*;

  logic        is_max;
  lane_flags_t head;
  lane_flags_t flags;
  elen_t       pick_b;
  elen_t       cmp_word;
  elen_t       res_d;

  assign is_max = req_i.op inside {VMAX, VMAXU};

  ////////////////////////////////////////
  // Lane masks for min/max and compares

  always_comb begin
    head     = '0;
    pick_b   = '0;
    cmp_word = '0;
    for (int j = 0; j < NumLanes8; j++) begin
      head[j] = (j & ((1 << cfg_i.vew) - 1)) == 0;
      // Every byte follows the flag of its element's lowest lane
      pick_b[8*j +: 8] = {8{less_i[(j >> cfg_i.vew) << cfg_i.vew] ^ is_max}};
      cmp_word[8*j]    = head[j] & flags[j];
    end
  end

  always_comb begin
    unique case (req_i.op)
      VMSEQ:          flags = equal_i;
      VMSNE:          flags = ~equal_i;
      VMSLT, VMSLTU:  flags = less_i;
      VMSLE, VMSLEU:  flags = less_i | equal_i;
      VMSGT, VMSGTU:  flags = ~(less_i | equal_i);
      default:        flags = '0;
    endcase
  end

  ////////////////////////////////////////
  // Result select

  always_comb begin
    unique case (req_i.op)
      VADD, VSUB, VRSUB, VSADDU, VSADD, VSSUBU, VSSUB,
      VAADDU, VAADD:            res_d = add_res_i;
      VAND:                     res_d = req_i.opa & req_i.opb;
      VOR:                      res_d = req_i.opa | req_i.opb;
      VXOR:                     res_d = req_i.opa ^ req_i.opb;
      VSLL, VSRL, VSRA:         res_d = shift_res_i;
      VMINU, VMIN, VMAXU, VMAX: res_d = (req_i.opb & pick_b) | (req_i.opa & ~pick_b);
      VMSEQ, VMSNE, VMSLTU, VMSLT, VMSLEU, VMSLE,
      VMSGTU, VMSGT:            res_d = cmp_word;
      default:                  res_d = '0;
    endcase
  end

  // Adder flags lanes only for saturating ops
  assign sat_set_o = valid_i & (|sat_lanes_i);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_o  <= 1'b0;
      result_o <= '0;
    end else begin
      valid_o <= valid_i;
      if (valid_i) begin
        result_o <= res_d;
      end
    end
  end

endmodule

// File: rtl/simd_alu_pkg.sv
/*
 * Shared types, encodings and element helpers for the SIMD integer ALU.
 * Every datapath unit imports this package and splits the 64-bit word into
 * elements with the helper functions below.
 */

package simd_alu_pkg;

  localparam int unsigned ElenBits  = 64;
  localparam int unsigned NumLanes8 = ElenBits / 8;
  // Two guard bits keep any sum or difference of extended elements exact
  localparam int unsigned ExtBits   = ElenBits + 2;

  typedef logic [ElenBits-1:0]  elen_t;
  typedef logic [NumLanes8-1:0] lane_flags_t;
  typedef logic [ExtBits-1:0]   ext_t;

  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  // Fixed-point rounding modes
  typedef enum logic [1:0] {
    RNU = 2'd0,
    RNE = 2'd1,
    RDN = 2'd2,
    ROD = 2'd3
  } vxrm_e;

  typedef enum logic [4:0] {
    VADD, VSUB, VRSUB,
    VSADDU, VSADD, VSSUBU, VSSUB,
    VAADDU, VAADD,
    VAND, VOR, VXOR,
    VSLL, VSRL, VSRA,
    VMINU, VMIN, VMAXU, VMAX,
    VMSEQ, VMSNE, VMSLTU, VMSLT, VMSLEU, VMSLE, VMSGTU, VMSGT
  } alu_op_e;

  typedef struct packed {
    alu_op_e op;
    elen_t   opa;
    elen_t   opb;
  } alu_req_t;

  typedef struct packed {
    vew_e  vew;
    vxrm_e vxrm;
  } alu_cfg_t;

  ////////////////////////////////////////
  // Element helpers

  function automatic int unsigned ew_bits(vew_e vew);
    return 8 << vew;
  endfunction

  function automatic int unsigned ew_count(vew_e vew);
    return NumLanes8 >> vew;
  endfunction

  function automatic elen_t ew_mask(vew_e vew);
    return (vew == EW64) ? '1 : (elen_t'(1) << ew_bits(vew)) - elen_t'(1);
  endfunction

  // Element idx, zero or sign extended to the full guarded width
  function automatic ext_t elem_ext(elen_t word, vew_e vew, int unsigned idx, logic sgn);
    elen_t mask;
    elen_t val;
    logic  msb;
    mask = ew_mask(vew);
    val  = (word >> (idx * ew_bits(vew))) & mask;
    msb  = sgn & val[ew_bits(vew) - 1];
    return {{2{msb}}, val | (msb ? ~mask : '0)};
  endfunction

  // Merge val into element idx of a word whose slot is still zero
  function automatic elen_t elem_put(elen_t word, vew_e vew, int unsigned idx, elen_t val);
    return word | ((val & ew_mask(vew)) << (idx * ew_bits(vew)));
  endfunction

endpackage

// File: rtl/simd_alu_top.sv
/*
 * Top level of the registered 64-bit SIMD integer ALU.
 * Wires the config block, the three combinational datapath units and the
 * writeback register. Results appear one cycle after valid_i.
 */

`timescale 1ns/1ns

module simd_alu_top (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   cfg_we_i,
  input  simd_alu_pkg::alu_cfg_t cfg_i,
  input  logic                   valid_i,
  input  simd_alu_pkg::alu_req_t req_i,
  output logic                   valid_o,
  output simd_alu_pkg::elen_t    result_o,
  output logic                   vxsat_o
);

  import simd_alu_pkg::*;

  alu_cfg_t    cfg;
  lane_flags_t less;
  lane_flags_t equal;
  elen_t       add_res;
  lane_flags_t sat_lanes;
  elen_t       shift_res;
  logic        sat_set;

  alu_csr i_alu_csr (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .cfg_we_i  (cfg_we_i),
    .cfg_i     (cfg_i),
    .sat_set_i (sat_set),
    .cfg_o     (cfg),
    .vxsat_o   (vxsat_o)
  );

  alu_compare i_alu_compare (
    .req_i   (req_i),
    .cfg_i   (cfg),
    .less_o  (less),
    .equal_o (equal)
  );

  alu_adder i_alu_adder (
    .req_i       (req_i),
    .cfg_i       (cfg),
    .add_res_o   (add_res),
    .sat_lanes_o (sat_lanes)
  );

  alu_shifter i_alu_shifter (
    .req_i       (req_i),
    .cfg_i       (cfg),
    .shift_res_o (shift_res)
  );

  alu_writeback i_alu_writeback (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .valid_i     (valid_i),
    .req_i       (req_i),
    .cfg_i       (cfg),
    .less_i      (less),
    .equal_i     (equal),
    .add_res_i   (add_res),
    .sat_lanes_i (sat_lanes),
    .shift_res_i (shift_res),
    .result_o    (result_o),
    .valid_o     (valid_o),
    .sat_set_o   (sat_set)
  );

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds the SIMD ALU testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_simd_alu -o tb_simd_alu
./obj_dir/tb_simd_alu > sim.log 2>&1
cat sim.log
if grep -q "Simulation finished: FAIL" sim.log; then
  exit 1
fi
grep -q "Simulation finished: PASS" sim.log

// File: verif/alu_input.txt
# C <element width in bits> <rounding mode>, G idles one cycle
# O <opcode> <operand a> <operand b> <expected result> <expected vxsat>, values in hex
# Wrapping add and subtract at the reset width of 8 bits
O VADD   01027F80FF102030 FFFF018001F0E0D0 0001800000000000 0
O VSUB   01027F80FF102030 FFFF018001F0E0D0 FEFD820002E0C0A0 0
O VRSUB  01027F80FF102030 FFFF018001F0E0D0 02037E00FE204060 0
G
O VADD   FFFFFFFFFFFFFFFF 0101010101010101 0000000000000000 0
# Element boundaries
C 16 RNU
O VADD   FFFFFFFFFFFFFFFF 0101010101010101 0100010001000100 0
C 32 RNU
O VADD   FFFFFFFFFFFFFFFF 0101010101010101 0101010001010100 0
C 64 RNU
O VADD   FFFFFFFFFFFFFFFF 0101010101010101 0101010101010100 0
O VSUB   0001000000010000 0000000000000000 FFFEFFFFFFFF0000 0
C 16 RNU
O VSUB   0001000000010000 0000000000000000 FFFF0000FFFF0000 0
# Saturation and the sticky flag
C 8 RNU
O VSADDU F01080017F00FF02 201080FE01000103 FF20FFFF8000FF05 1
O VADD   0101010101010101 0101010101010101 0202020202020202 1
C 8 RNU
O VADD   0101010101010101 0101010101010101 0202020202020202 0
O VSSUBU 1020304050607080 201030504060FF00 1000001000008F00 1
C 8 RNU
O VSADD  7F80800140C0FF00 01FF807F40C00100 7F80807F7F800000 1
C 16 RNU
O VSSUB  000180007FFFFFFF 80000001FFFF7FFF 80007FFF80007FFF 1
O VSUB   0001000100010001 0003000300030003 0002000200020002 1
# Averaging add in each rounding mode
C 8 RNU
O VAADDU 010203FFFF800581 000102FF01000280 010203FF80400481 0
O VAADD  010203FFFF800581 000102FF01000280 010203FF00C00481 0
C 8 RNE
O VAADDU 010203FFFF800581 000102FF01000280 000202FF80400480 0
O VAADD  010203FFFF800581 000102FF01000280 000202FF00C00480 0
C 8 RDN
O VAADDU 010203FFFF800581 000102FF01000280 000102FF80400380 0
O VAADD  010203FFFF800581 000102FF01000280 000102FF00C00380 0
C 8 ROD
O VAADDU 010203FFFF800581 000102FF01000280 010103FF80400381 0
O VAADD  010203FFFF800581 000102FF01000280 010103FF00C00381 0
# Shifts
C 8 RNU
O VSLL   01090700030F08FF 81818181F00F5580 0202808180805500 0
O VSRL   01090700030F08FF 81818181F00F5580 404001811E005501 0
O VSRA   01090700030F08FF 81818181F00F5580 C0C0FF81FE0055FF 0
C 32 RNU
O VSRA   000000210000001F 8000000180000001 C0000000FFFFFFFF 0
C 64 RNU
O VSRA   0000000000000044 F000000000000001 FF00000000000000 0
O VSLL   0000000000000044 F000000000000001 0000000000000010 0
# Min, max, compares and logic ops
C 8 RNU
O VMINU  807F01FF0010FF05 7F800100FF100103 7F7F010000100103 0
O VMIN   807F01FF0010FF05 7F800100FF100103 808001FFFF10FF03 0
O VMAXU  807F01FF0010FF05 7F800100FF100103 808001FFFF10FF05 0
O VMAX   807F01FF0010FF05 7F800100FF100103 7F7F010000100105 0
O VMSEQ  807F01FF0010FF05 7F800100FF100103 0000010000010000 0
O VMSNE  807F01FF0010FF05 7F800100FF100103 0101000101000101 0
O VMSLTU 807F01FF0010FF05 7F800100FF100103 0100000100000101 0
O VMSLT  807F01FF0010FF05 7F800100FF100103 0001000001000001 0
O VMSLEU 807F01FF0010FF05 7F800100FF100103 0100010100010101 0
O VMSLE  807F01FF0010FF05 7F800100FF100103 0001010001010001 0
O VMSGTU 807F01FF0010FF05 7F800100FF100103 0001000001000000 0
O VMSGT  807F01FF0010FF05 7F800100FF100103 0100000100000100 0
O VAND   F0F0FF00AA551234 FF00F0F05555FFFF F000F00000551234 0
O VOR    F0F0FF00AA551234 FF00F0F05555FFFF FFF0FFF0FF55FFFF 0
O VXOR   F0F0FF00AA551234 FF00F0F05555FFFF 0FF00FF0FF00EDCB 0
C 16 RNU
O VMSLTU 800000010005FFFF 7FFF000100030000 0001000000010001 0
O VMSLT  800000010005FFFF 7FFF000100030000 0000000000010000 0
O VMSGT  800000010005FFFF 7FFF000100030000 0001000000000001 0

// File: verif/tb_simd_alu.sv
/*
 * Testbench for the registered SIMD integer ALU.
 * Reads config writes and operation vectors from verif/alu_input.txt,
 * drives one line per clock and checks result and vxsat one cycle later.
 */

`timescale 1ns/1ns

module tb_simd_alu;

  import simd_alu_pkg::*;

  localparam int unsigned MaxLines  = 256;
  localparam int unsigned ClkPeriod = 40;

  logic     clk;
  logic     reset;
  logic     cfg_we;
  alu_cfg_t cfg_data;
  logic     req_valid;
  alu_req_t req_data;
  logic     out_valid;
  elen_t    out_result;
  logic     out_vxsat;

  // Parsed vector file
  logic [7:0]  kind_mem    [MaxLines];
  alu_cfg_t    cfg_mem     [MaxLines];
  alu_req_t    req_mem     [MaxLines];
  elen_t       exp_res_mem [MaxLines];
  logic        exp_sat_mem [MaxLines];
  int unsigned num_lines;

  // Outstanding requests, oldest first
  elen_t   exp_res_q [$];
  logic    exp_sat_q [$];
  alu_op_e exp_op_q  [$];
  time     exp_due_q [$];

  int          res_errors;
  int          sat_errors;
  int          proto_errors;
  int unsigned cycles;
  int unsigned cycle_limit;

  simd_alu_top i_simd_alu_top (
    .clk_i    (clk),
    .reset_i  (reset),
    .cfg_we_i (cfg_we),
    .cfg_i    (cfg_data),
    .valid_i  (req_valid),
    .req_i    (req_data),
    .valid_o  (out_valid),
    .result_o (out_result),
    .vxsat_o  (out_vxsat)
  );

  always #(ClkPeriod / 2) clk = ~clk;

  ////////////////////////////////////////
  // Vector file

  function automatic logic parse_op(input string name, output alu_op_e op);
    alu_op_e cand;
    cand = cand.first();
    op   = cand;
    for (int i = 0; i < cand.num(); i++) begin
      if (cand.name() == name) begin
        op = cand;
        return 1'b1;
      end
      cand = cand.next();
    end
    return 1'b0;
  endfunction

  function automatic logic parse_vew(input int bits, output vew_e vew);
    vew = EW8;
    if (bits == 8) vew = EW8;
    else if (bits == 16) vew = EW16;
    else if (bits == 32) vew = EW32;
    else if (bits == 64) vew = EW64;
    else return 1'b0;
    return 1'b1;
  endfunction

  function automatic logic parse_vxrm(input string name, output vxrm_e vxrm);
    vxrm = RNU;
    if (name == "RNU") vxrm = RNU;
    else if (name == "RNE") vxrm = RNE;
    else if (name == "RDN") vxrm = RDN;
    else if (name == "ROD") vxrm = ROD;
    else return 1'b0;
    return 1'b1;
  endfunction

  task automatic read_vectors();
    int      fd;
    int      ch;
    int      bits;
    int      sat;
    logic    ok;
    string   kind;
    string   name;
    string   mode;
    elen_t   a;
    elen_t   b;
    elen_t   res;
    alu_op_e op;
    vew_e    vew;
    vxrm_e   vxrm;
    num_lines = 0;
    ok        = 1'b1;
    fd = $fopen("verif/alu_input.txt", "r");
    if (fd == 0) begin
      $display("Cannot open verif/alu_input.txt, no vectors were run");
      proto_errors++;
      return;
    end
    while (ok && $fscanf(fd, "%s", kind) == 1) begin
      if (kind.getc(0) == "#") begin
        // Skip the rest of a comment line
        do begin
          ch = $fgetc(fd);
        end while (ch != 10 && ch != -1);
      end else if (num_lines >= MaxLines) begin
        $display("Vector file holds more than %0d lines", MaxLines);
        ok = 1'b0;
      end else if (kind == "G") begin
        kind_mem[num_lines] = "G";
        num_lines++;
      end else if (kind == "C") begin
        ok = ($fscanf(fd, "%d %s", bits, mode) == 2);
        ok = ok && parse_vew(bits, vew) && parse_vxrm(mode, vxrm);
        kind_mem[num_lines]     = "C";
        cfg_mem[num_lines].vew  = vew;
        cfg_mem[num_lines].vxrm = vxrm;
        num_lines++;
      end else if (kind == "O") begin
        ok = ($fscanf(fd, "%s %h %h %h %d", name, a, b, res, sat) == 5);
        ok = ok && parse_op(name, op);
        kind_mem[num_lines]    = "O";
        req_mem[num_lines].op  = op;
        req_mem[num_lines].opa = a;
        req_mem[num_lines].opb = b;
        exp_res_mem[num_lines] = res;
        exp_sat_mem[num_lines] = (sat != 0);
        num_lines++;
      end else begin
        ok = 1'b0;
      end
    end
    if (!ok) begin
      $display("Malformed entry after line %0d of the vector file", num_lines);
      proto_errors++;
    end
    $fclose(fd);
  endtask

  ////////////////////////////////////////
  // Stimulus

  task automatic drive_vectors();
    for (int unsigned i = 0; i < num_lines; i++) begin
      @(posedge clk);
      cfg_we    <= 1'b0;
      req_valid <= 1'b0;
      if (kind_mem[i] == "C") begin
        cfg_we   <= 1'b1;
        cfg_data <= cfg_mem[i];
      end else if (kind_mem[i] == "O") begin
        req_valid <= 1'b1;
        req_data  <= req_mem[i];
        exp_res_q.push_back(exp_res_mem[i]);
        exp_sat_q.push_back(exp_sat_mem[i]);
        exp_op_q.push_back(req_mem[i].op);
        // Sampled on the next edge, visible to the checker one edge later
        exp_due_q.push_back($time + 2 * ClkPeriod);
      end
    end
    @(posedge clk);
    cfg_we    <= 1'b0;
    req_valid <= 1'b0;
  endtask

  task automatic check_reset_state();
    if (out_valid !== 1'b0 || out_result !== '0 || out_vxsat !== 1'b0) begin
      $display("ERR %0t: after reset valid %b result %h vxsat %b, expected all zero",
               $time, out_valid, out_result, out_vxsat);
      res_errors++;
    end
  endtask

  ////////////////////////////////////////
  // Checking

  // Outputs are read before this edge updates them
  always @(posedge clk) begin : check_outputs
    elen_t   want_res;
    logic    want_sat;
    alu_op_e want_op;
    logic    due;
    if (!reset) begin
      due = 1'b0;
      if (exp_due_q.size() != 0) begin
        due = (exp_due_q[0] == $time);
      end
      if (out_valid && !due) begin
        $display("valid_o was high at %0t with no result due", $time);
        proto_errors++;
      end else if (due) begin
        void'(exp_due_q.pop_front());
        want_res = exp_res_q.pop_front();
        want_sat = exp_sat_q.pop_front();
        want_op  = exp_op_q.pop_front();
        if (!out_valid) begin
          $display("valid_o stayed low at %0t when the %s result was due",
                   $time, want_op.name());
          proto_errors++;
        end else begin
          if (out_result !== want_res) begin
            $display("ERR %0t: %s result %h, expected %h",
                     $time, want_op.name(), out_result, want_res);
            res_errors++;
          end
          if (out_vxsat !== want_sat) begin
            $display("ERR %0t: %s vxsat %b, expected %b",
                     $time, want_op.name(), out_vxsat, want_sat);
            sat_errors++;
          end
        end
      end
    end
  end

  always @(posedge clk) begin : watchdog
    cycles = cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Run stopped after %0d cycles with %0d results outstanding",
               cycles, exp_res_q.size());
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  initial begin : main
    int total;
    clk          = 1'b0;
    reset        = 1'b1;
    cfg_we       = 1'b0;
    cfg_data     = '0;
    req_valid    = 1'b0;
    req_data     = '0;
    res_errors   = 0;
    sat_errors   = 0;
    proto_errors = 0;
    cycles       = 0;
    cycle_limit  = 50;

    read_vectors();
    cycle_limit = 2 * num_lines + 50;

    repeat (5) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    check_reset_state();

    drive_vectors();
    repeat (3) @(posedge clk);
    if (exp_res_q.size() != 0) begin
      $display("%0d requests never produced a result", exp_res_q.size());
      proto_errors++;
    end

    total = res_errors + sat_errors + proto_errors;
    $display("Errors: %0d result, %0d vxsat, %0d protocol", res_errors, sat_errors,
             proto_errors);
    if (total == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: vlog.f
rtl/simd_alu_pkg.sv
rtl/alu_csr.sv
rtl/alu_compare.sv
rtl/alu_adder.sv
rtl/alu_shifter.sv
rtl/alu_writeback.sv
rtl/simd_alu_top.sv
verif/tb_simd_alu.sv
